//--- hw/apb_defs.svh
// ************************************************
// Bus widths, select field, completer map and wait states
// Base list order must match completer index order
// ************************************************

`ifndef APB_DEFS_SVH
`define APB_DEFS_SVH

// Bus widths
`define APB_BW_ADDR 32
`define APB_BW_DATA 32

// Select field sits at the top of the address
`define APB_SEL_UPPER 31
`define APB_BW_SEL 4

// Completer map
`define APB_NUM_SLAVES 3
`define APB_SLV0_BASE 32'h1000_0000
`define APB_SLV1_BASE 32'h2000_0000
`define APB_SLV2_BASE 32'h3000_0000

// Fixed wait states per completer
`define APB_SLV0_WAIT 0
`define APB_SLV1_WAIT 1
`define APB_SLV2_WAIT 2

`endif

//--- hw/apb_pkg.sv
// ************************************************
// Shared bus types, sized from the bus macros
// ************************************************

`default_nettype none

`include "apb_defs.svh"

package apb_pkg;

	// ************************************************
	// Payload words
	// ************************************************

	// Byte address on the requester side
	typedef logic [`APB_BW_ADDR-1:0] apb_addr_t;

	// Read and write data word
	typedef logic [`APB_BW_DATA-1:0] apb_data_t;

	// ************************************************
	// Per-completer vectors
	// ************************************************

	// One bit per completer, bit i is completer i
	typedef logic [`APB_NUM_SLAVES-1:0] apb_slv_vec_t;

endpackage

`default_nettype wire

//--- hw/apb_reg_bank.sv
// ************************************************
// Four 32-bit registers at offsets 0x0..0xC, byte lanes ignored
// Bits 27:4 must be zero, else error with no write
// ************************************************

`timescale 1ns/1ps
`default_nettype none

`include "apb_defs.svh"

module apb_reg_bank
#(
	// Extra access cycles before ready
	parameter int WAIT_CYCLES = 0
)
(
	input wire clk,
	input wire rst,

	input wire psel,
	input wire penable,
	input wire apb_pkg::apb_addr_t paddr,
	input wire pwrite,
	input wire apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WAIT_CYCLES);

logic access;
logic range_err;
logic [1:0] reg_idx;
logic [CNT_W-1:0] wait_cnt;
apb_pkg::apb_data_t regs [0:3];

// ************************************************
// Address checks
// ************************************************

assign access = psel & penable;

// Anything between the select field and the register offset is out of bank
assign range_err = |paddr[`APB_SEL_UPPER-`APB_BW_SEL:4];
assign reg_idx = paddr[3:2];

// ************************************************
// Wait-state counter
// ************************************************

// Counts access cycles, cleared on ready and outside access
always_ff @(posedge clk)
begin
	if (rst)
		wait_cnt <= '0;
	else if (access && !pready)
		wait_cnt <= wait_cnt + CNT_W'(1);
	else
		wait_cnt <= '0;
end

// Ready in access cycle WAIT_CYCLES+1
assign pready = access && (wait_cnt == CNT_LAST);
assign pslverr = pready && range_err;

// ************************************************
// Register file
// ************************************************

// Write lands on the ready edge
always_ff @(posedge clk)
begin
	if (rst)
	begin
		for (int i = 0; i < 4; i++)
			regs[i] <= '0;
	end
	else if (pready && pwrite && !range_err)
	begin
		regs[reg_idx] <= pwdata;
	end
end

// Read data only on a good read, zero otherwise
assign prdata = (access && !pwrite && !range_err) ? regs[reg_idx] : '0;

// Requester must not raise enable without select
assert property (@(posedge clk) disable iff (rst) penable |-> psel)
	else $error("apb_reg_bank: penable without psel");

// Ready only in an access phase, right after setup or a waiting access cycle
assert property (@(posedge clk) disable iff (rst) pready |-> $past(psel && !pready))
	else $error("apb_reg_bank: pready outside an access phase");

endmodule

`default_nettype wire

//--- hw/apb_bus_router.sv
// ************************************************
// Purely combinational between requester and completers
// Unmapped access completes in the first access cycle with an error
// ************************************************

`timescale 1ns/1ps
`default_nettype none

`include "apb_defs.svh"

module apb_bus_router
(
	// Clock and reset only for the hit check
	input wire clk,
	input wire rst,

	// Requester side
	input wire psel,
	input wire penable,
	input wire apb_pkg::apb_addr_t paddr,
	input wire pwrite,
	input wire apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,

	// Decoded hit, one bit per completer
	input wire apb_pkg::apb_slv_vec_t hit,

	// Completer side
	output apb_pkg::apb_slv_vec_t spsel,
	output apb_pkg::apb_slv_vec_t spenable,
	output apb_pkg::apb_addr_t [`APB_NUM_SLAVES-1:0] spaddr,
	output apb_pkg::apb_slv_vec_t spwrite,
	output apb_pkg::apb_data_t [`APB_NUM_SLAVES-1:0] spwdata,
	input wire apb_pkg::apb_data_t [`APB_NUM_SLAVES-1:0] sprdata,
	input wire apb_pkg::apb_slv_vec_t spready,
	input wire apb_pkg::apb_slv_vec_t spslverr
);

localparam int IDX_W = (`APB_NUM_SLAVES > 1) ? $clog2(`APB_NUM_SLAVES) : 1;

logic [IDX_W-1:0] hit_idx;
logic no_hit;
logic access;

// ************************************************
// Request steering
// ************************************************

// Strobes only reach the completer that was hit
assign spsel = {`APB_NUM_SLAVES{psel}} & hit;
assign spenable = {`APB_NUM_SLAVES{penable}} & hit;

// Direction, address and data go to everyone
assign spwrite = {`APB_NUM_SLAVES{pwrite}};
assign spaddr = {`APB_NUM_SLAVES{paddr}};
assign spwdata = {`APB_NUM_SLAVES{pwdata}};

// ************************************************
// Response path
// ************************************************

assign no_hit = ~|hit;
assign access = psel & penable;

// Encode the hit bit, stays at 0 when nothing hits
always_comb
begin
	hit_idx = '0;
	for (int i = 0; i < `APB_NUM_SLAVES; i++)
	begin
		if (hit[i])
			hit_idx = IDX_W'(i);
	end
end

// Unmapped space answers at once with an error and zero data
always_comb
begin
	if (no_hit)
	begin
		prdata = '0;
		pready = access;
		pslverr = access;
	end
	else
	begin
		prdata = sprdata[hit_idx];
		pready = spready[hit_idx];
		pslverr = spslverr[hit_idx];
	end
end

// Base list must not overlap on the select field
assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
	else $error("apb_bus_router: more than one completer hit");

endmodule

`default_nettype wire

//--- hw/apb_bus.sv
// ************************************************
// Address decode on the select field only
// Overlapping bases give a multi-hit, caught in the router
// ************************************************

`timescale 1ns/1ps
`default_nettype none

`include "apb_defs.svh"

module apb_bus
#(
	// Packed bases, entry 0 in the low word
	parameter logic [`APB_NUM_SLAVES*`APB_BW_ADDR-1:0] BASE_LIST = '0
)
(
	input wire clk,
	input wire rst,

	// Requester side
	input wire psel,
	input wire penable,
	input wire apb_pkg::apb_addr_t paddr,
	input wire pwrite,
	input wire apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,

	// Completer side
	output apb_pkg::apb_slv_vec_t spsel,
	output apb_pkg::apb_slv_vec_t spenable,
	output apb_pkg::apb_addr_t [`APB_NUM_SLAVES-1:0] spaddr,
	output apb_pkg::apb_slv_vec_t spwrite,
	output apb_pkg::apb_data_t [`APB_NUM_SLAVES-1:0] spwdata,
	input wire apb_pkg::apb_data_t [`APB_NUM_SLAVES-1:0] sprdata,
	input wire apb_pkg::apb_slv_vec_t spready,
	input wire apb_pkg::apb_slv_vec_t spslverr
);

// ************************************************
// Hit vector
// ************************************************

wire apb_pkg::apb_slv_vec_t hit;

// Split the base list and compare the top field of each entry
for (genvar i = 0; i < `APB_NUM_SLAVES; i++)
begin : g_decode
	localparam apb_pkg::apb_addr_t BASE = BASE_LIST[i*`APB_BW_ADDR +: `APB_BW_ADDR];

	assign hit[i] = (paddr[`APB_SEL_UPPER -: `APB_BW_SEL] == BASE[`APB_SEL_UPPER -: `APB_BW_SEL]);
end

// ************************************************
// Steering
// ************************************************

apb_bus_router apb_bus_router_inst
(
	.clk(clk),
	.rst(rst),
	.psel(psel),
	.penable(penable),
	.paddr(paddr),
	.pwrite(pwrite),
	.pwdata(pwdata),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr),
	.hit(hit),
	.spsel(spsel),
	.spenable(spenable),
	.spaddr(spaddr),
	.spwrite(spwrite),
	.spwdata(spwdata),
	.sprdata(sprdata),
	.spready(spready),
	.spslverr(spslverr)
);

endmodule

`default_nettype wire

//--- hw/apb_subsystem_top.sv
// ************************************************
// One requester port, three banks at 0x1/0x2/0x3 in the top nibble
// ************************************************

`timescale 1ns/1ps
`default_nettype none

`include "apb_defs.svh"

module apb_subsystem_top
(
	input wire clk,
	input wire rst,

	// Requester port
	input wire psel,
	input wire penable,
	input wire apb_pkg::apb_addr_t paddr,
	input wire pwrite,
	input wire apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

// Entry 0 in the low word
localparam logic [`APB_NUM_SLAVES*`APB_BW_ADDR-1:0] BASE_LIST =
	{`APB_SLV2_BASE, `APB_SLV1_BASE, `APB_SLV0_BASE};

// ************************************************
// Completer wiring
// ************************************************

apb_pkg::apb_slv_vec_t spsel;
apb_pkg::apb_slv_vec_t spenable;
apb_pkg::apb_slv_vec_t spwrite;
apb_pkg::apb_addr_t [`APB_NUM_SLAVES-1:0] spaddr;
apb_pkg::apb_data_t [`APB_NUM_SLAVES-1:0] spwdata;
apb_pkg::apb_data_t [`APB_NUM_SLAVES-1:0] sprdata;
apb_pkg::apb_slv_vec_t spready;
apb_pkg::apb_slv_vec_t spslverr;

apb_bus #(.BASE_LIST(BASE_LIST)) apb_bus_inst
(
	.clk(clk), .rst(rst),
	.psel(psel), .penable(penable), .paddr(paddr), .pwrite(pwrite), .pwdata(pwdata),
	.prdata(prdata), .pready(pready), .pslverr(pslverr),
	.spsel(spsel), .spenable(spenable), .spaddr(spaddr), .spwrite(spwrite),
	.spwdata(spwdata), .sprdata(sprdata), .spready(spready), .spslverr(spslverr)
);

// ************************************************
// Register banks
// ************************************************

// Bank 0, no wait states
apb_reg_bank #(.WAIT_CYCLES(`APB_SLV0_WAIT)) bank0_inst
(
	.clk(clk), .rst(rst),
	.psel(spsel[0]), .penable(spenable[0]), .paddr(spaddr[0]),
	.pwrite(spwrite[0]), .pwdata(spwdata[0]),
	.prdata(sprdata[0]), .pready(spready[0]), .pslverr(spslverr[0])
);

// Bank 1, one wait state
apb_reg_bank #(.WAIT_CYCLES(`APB_SLV1_WAIT)) bank1_inst
(
	.clk(clk), .rst(rst),
	.psel(spsel[1]), .penable(spenable[1]), .paddr(spaddr[1]),
	.pwrite(spwrite[1]), .pwdata(spwdata[1]),
	.prdata(sprdata[1]), .pready(spready[1]), .pslverr(spslverr[1])
);

// Bank 2, two wait states
apb_reg_bank #(.WAIT_CYCLES(`APB_SLV2_WAIT)) bank2_inst
(
	.clk(clk), .rst(rst),
	.psel(spsel[2]), .penable(spenable[2]), .paddr(spaddr[2]),
	.pwrite(spwrite[2]), .pwdata(spwdata[2]),
	.prdata(sprdata[2]), .pready(spready[2]), .pslverr(spslverr[2])
);

endmodule

`default_nettype wire

//--- test/tb_apb_subsystem.sv
// ************************************************
// Runs from the project root, reads test/apb_tests.txt
// One APB transfer per line, random idle gaps between them
// ************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_apb_subsystem;

// Access cycles allowed before a transfer is abandoned
localparam int ACCESS_LIMIT = 16;

logic clk;
logic rst;
logic psel;
logic penable;
apb_pkg::apb_addr_t paddr;
logic pwrite;
apb_pkg::apb_data_t pwdata;
wire apb_pkg::apb_data_t prdata;
wire pready;
wire pslverr;

int check_errors;
int timeout_errors;
int seed;

apb_subsystem_top apb_subsystem_top_inst
(
	.clk(clk), .rst(rst),
	.psel(psel), .penable(penable), .paddr(paddr), .pwrite(pwrite), .pwdata(pwdata),
	.prdata(prdata), .pready(pready), .pslverr(pslverr)
);

// 4 ns period
always #2 clk = ~clk;

// ************************************************
// Bus driving
// ************************************************

// Drive point just after a rising edge
task automatic next_slot();
	@(posedge clk);
	#0.5;
endtask

// One cycle with the bus idle
task automatic idle_cycle();
	next_slot();
	psel = 1'b0;
	penable = 1'b0;
endtask

// Setup, then access until pready, sampled mid-cycle
task automatic run_transfer(input logic is_write, input apb_pkg::apb_addr_t addr,
	input apb_pkg::apb_data_t wdata, output apb_pkg::apb_data_t rdata,
	output logic err, output int cycles, output logic timed_out);
	logic done;
	next_slot();
	psel = 1'b1;
	penable = 1'b0;
	paddr = addr;
	pwrite = is_write;
	pwdata = wdata;
	next_slot();
	penable = 1'b1;
	done = 1'b0;
	cycles = 0;
	rdata = '0;
	err = 1'b0;
	// Signals stay put until the ready edge
	while (!done && cycles < ACCESS_LIMIT)
	begin
		@(negedge clk);
		cycles++;
		if (pready)
		begin
			done = 1'b1;
			rdata = prdata;
			err = pslverr;
		end
	end
	timed_out = !done;
endtask

// ************************************************
// Test sequence
// ************************************************

initial
begin
	int fd;
	int n;
	int fields;
	int gap;
	int line_no;
	int transfers;
	int cycles;
	int exp_cycles;
	string line;
	logic [7:0] op;
	logic exp_err;
	logic err;
	logic timed_out;
	apb_pkg::apb_addr_t addr;
	apb_pkg::apb_data_t data;
	apb_pkg::apb_data_t rdata;

	seed = 27839;
	check_errors = 0;
	timeout_errors = 0;
	line_no = 0;
	transfers = 0;
	clk = 1'b0;
	rst = 1'b1;
	psel = 1'b0;
	penable = 1'b0;
	paddr = '0;
	pwrite = 1'b0;
	pwdata = '0;

	// Reset over three rising edges
	repeat (3) @(posedge clk);
	#0.5;
	rst = 1'b0;

	fd = $fopen("test/apb_tests.txt", "r");
	if (fd == 0)
	begin
		$display("Could not open the test file test/apb_tests.txt");
		check_errors++;
	end
	else
	begin
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			line_no++;
			fields = 0;
			// Header lines start with #
			if (n > 0 && line[0] != "#")
				fields = $sscanf(line, "%c %h %h %d %d", op, addr, data, exp_err, exp_cycles);
			if (fields == 5)
			begin
				transfers++;
				run_transfer(op == "W", addr, data, rdata, err, cycles, timed_out);
				if (timed_out)
				begin
					$display("Timeout: pready never came within %0d access cycles, line %0d",
						ACCESS_LIMIT, line_no);
					timeout_errors++;
					idle_cycle();
				end
				else
				begin
					assert (err == exp_err)
					else
					begin
						$display("CHECK FAILED at %0t: line %0d pslverr %0b, expected %0b",
							$time, line_no, err, exp_err);
						check_errors++;
					end
					assert (cycles == exp_cycles)
					else
					begin
						$display("CHECK FAILED at %0t: line %0d took %0d access cycles, expected %0d",
							$time, line_no, cycles, exp_cycles);
						check_errors++;
					end
					if (op == "R")
					begin
						assert (rdata == data)
						else
						begin
							$display("CHECK FAILED at %0t: line %0d prdata %h, expected %h",
								$time, line_no, rdata, data);
							check_errors++;
						end
					end
				end
				// Idle gap of 0 to 3 cycles
				gap = {$random(seed)} % 4;
				repeat (gap) idle_cycle();
			end
		end
		$fclose(fd);
	end

	if (transfers == 0)
	begin
		$display("No transfers were found in the test file");
		check_errors++;
	end
	idle_cycle();

	$display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
	if (check_errors == 0 && timeout_errors == 0)
		$display("ALL CHECKS PASSED");
	else
		$display("CHECKS FAILED");
	$finish;
end

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/apb_pkg.sv
hw/apb_reg_bank.sv
hw/apb_bus_router.sv
hw/apb_bus.sv
hw/apb_subsystem_top.sv
test/tb_apb_subsystem.sv

//--- Makefile
# Verilator build and run for the APB subsystem testbench
VERILATOR ?= verilator
TOP ?= tb_apb_subsystem
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/apb_tests.txt
# op address data slverr access_cycles, all numbers hex except the last two
# R compares data with the read value, W writes data
R 10000000 00000000 0 1
R 10000004 00000000 0 1
R 10000008 00000000 0 1
R 1000000C 00000000 0 1
R 20000000 00000000 0 2
R 20000004 00000000 0 2
R 20000008 00000000 0 2
R 2000000C 00000000 0 2
R 30000000 00000000 0 3
R 30000004 00000000 0 3
R 30000008 00000000 0 3
R 3000000C 00000000 0 3
W 10000000 A5A50000 0 1
W 10000004 A5A50004 0 1
W 10000008 A5A50008 0 1
W 1000000C A5A5000C 0 1
W 30000000 C3C30000 0 3
W 30000004 C3C30004 0 3
W 30000008 C3C30008 0 3
W 3000000C C3C3000C 0 3
W 20000000 5A5A0000 0 2
W 20000004 5A5A0004 0 2
W 20000008 5A5A0008 0 2
W 2000000C 5A5A000C 0 2
W 50000000 DEADBEEF 1 1
R 50000000 00000000 1 1
W 20000010 0BADF00D 1 2
R 20000010 00000000 1 2
R 10000000 A5A50000 0 1
R 10000004 A5A50004 0 1
R 10000008 A5A50008 0 1
R 1000000C A5A5000C 0 1
R 20000000 5A5A0000 0 2
R 20000004 5A5A0004 0 2
R 20000008 5A5A0008 0 2
R 2000000C 5A5A000C 0 2
R 30000000 C3C30000 0 3
R 30000004 C3C30004 0 3
R 30000008 C3C30008 0 3
R 3000000C C3C3000C 0 3
